// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the instruction queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_iq_subsystem \
  -f sim.f \
  --Mdir obj_dir -o vsim

output="$(./obj_dir/vsim)"
echo "$output"

# pass only when the testbench printed its pass line
echo "$output" | grep -qx "NO ERRORS"

// ==== sim.f ====
+incdir+source
source/iq_pkg.sv
source/issue_if.sv
source/result_if.sv
source/instr_queue.sv
source/exec_lane.sv
source/writeback_arbiter.sv
source/iq_subsystem.sv
testbench/tb_iq_subsystem.sv

// ==== source/exec_lane.sv ====
`timescale 1ns/1ns
`include "iq_settings.svh"

module exec_lane (
  input  logic   clock,
  input  logic   reset_n,
  issue_if.lane  issue,
  result_if.lane result
);
  import iq_pkg::*;

  localparam int unsigned MUL_BITS_PER_STEP = 4;
  localparam int unsigned MUL_STEPS         = `IQ_DATA_BITS / MUL_BITS_PER_STEP;

  typedef logic [$clog2(MUL_STEPS)-1:0] step_t;

  lane_state_e state;
  step_t       step_count;
  data_t       alu_value;
  data_t       partial;
  data_t       mcand;
  data_t       mplier;
  data_t       res_value;   // result register that also accumulates while multiplying
  rob_slot_t   res_slot;

  assign issue.ready     = (state == LANE_IDLE) || (state == LANE_HOLD && result.take);
  assign result.valid    = (state == LANE_HOLD);
  assign result.rob_slot = res_slot;
  assign result.value    = res_value;

  always_comb begin
    case (issue.opcode)
      OP_ADD:  alu_value = issue.src_a + issue.src_b;
      OP_SUB:  alu_value = issue.src_a - issue.src_b;
      OP_XOR:  alu_value = issue.src_a ^ issue.src_b;
      default: alu_value = '0;  // mul starts from an empty accumulator
    endcase
  end

  // shift-and-add over the low bits of the multiplier
  always_comb begin
    partial = '0;
    for (int b = 0; b < MUL_BITS_PER_STEP; b++) begin
      if (mplier[b]) begin
        partial = partial + (mcand << b);
      end
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state      <= LANE_IDLE;
      step_count <= '0;
    end else begin
      case (state)
        LANE_MUL: begin
          step_count <= step_count + 1'b1;
          if (step_count == step_t'(MUL_STEPS - 1)) begin
            state <= LANE_HOLD;
          end
        end
        LANE_HOLD: if (result.take) state <= LANE_IDLE;
        default: ;
      endcase
      if (issue.issue) begin
        state      <= (issue.opcode == OP_MUL) ? LANE_MUL : LANE_HOLD;
        step_count <= '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue.issue) begin
      res_slot  <= issue.rob_slot;
      res_value <= alu_value;
      mcand     <= issue.src_a;
      mplier    <= issue.src_b;
    end else if (state == LANE_MUL) begin
      res_value <= res_value + partial;
      mcand     <= mcand << MUL_BITS_PER_STEP;
      mplier    <= mplier >> MUL_BITS_PER_STEP;
    end
  end

  a_issue_when_ready: assert property (@(posedge clock) disable iff (!reset_n)
    issue.issue |-> issue.ready);

endmodule

// ==== source/instr_queue.sv ====
`timescale 1ns/1ns
`include "iq_settings.svh"

module instr_queue (
  input  logic                clock,
  input  logic                reset_n,
  input  logic                ins_enable_i,
  input  iq_pkg::ins_count_t  ins_count_i,
  input  iq_pkg::iq_entry_t   ins_entries_i [`IQ_INS_COUNT],
  input  logic                flush_i,
  input  logic                flush_stream_i,
  issue_if.queue              issue [`IQ_LANE_COUNT],
  output logic                full_o,
  output logic                empty_o,
  output iq_pkg::used_count_t used_count_o
);
  import iq_pkg::*;

  iq_entry_t                 storage [`IQ_DEPTH];
  iq_ptr_t                   head;
  iq_ptr_t                   tail;

  iq_entry_t                 win_entry [`IQ_LANE_COUNT];
  logic [`IQ_LANE_COUNT-1:0] win_valid;
  iq_entry_t                 win_next [`IQ_LANE_COUNT];
  logic [`IQ_LANE_COUNT-1:0] win_valid_next;

  logic [`IQ_LANE_COUNT-1:0] lane_ready;
  logic [`IQ_LANE_COUNT-1:0] issue_vec;
  logic                      ins_accept;
  used_count_t               issue_count;
  used_count_t               ins_n;
  used_count_t               avail;
  used_count_t               flush_count;
  used_count_t               used_next;

  iq_entry_t                 merged [`IQ_DEPTH];  // contents after extract and insert
  logic [`IQ_DEPTH-1:0]      merged_valid;

  assign full_o     = (used_count_o > used_count_t'(`IQ_DEPTH - `IQ_INS_COUNT));
  assign empty_o    = (used_count_o == '0);
  assign ins_accept = ins_enable_i & ~full_o;  // a blocked insert is dropped whole
  assign ins_n      = ins_accept ? used_count_t'(ins_count_i) + 1'b1 : '0;
  assign avail      = used_count_o - issue_count;
  assign used_next  = avail + ins_n - flush_count;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // in-order issue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    logic chain;
    chain       = 1'b1;
    issue_count = '0;
    for (int k = 0; k < `IQ_LANE_COUNT; k++) begin
      chain        = chain & win_valid[k] & lane_ready[k];  // every lower lane must issue too
      issue_vec[k] = chain;
      issue_count  = issue_count + used_count_t'(chain);
    end
  end

  for (genvar g = 0; g < `IQ_LANE_COUNT; g++) begin : g_lane
    assign lane_ready[g]     = issue[g].ready;
    assign issue[g].issue    = issue_vec[g];
    assign issue[g].opcode   = win_entry[g].opcode;
    assign issue[g].src_a    = win_entry[g].src_a;
    assign issue[g].src_b    = win_entry[g].src_b;
    assign issue[g].rob_slot = win_entry[g].rob_slot;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // extract, insert, flush
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    iq_ptr_t     rd_ptr;
    used_count_t rel;
    rd_ptr = head + iq_ptr_t'(issue_count);
    for (int j = 0; j < `IQ_DEPTH; j++) begin
      rel             = used_count_t'(j) - avail;
      merged[j]       = storage[rd_ptr + iq_ptr_t'(j)];
      merged_valid[j] = 1'b0;
      if (used_count_t'(j) < avail) begin
        merged_valid[j] = 1'b1;
      end else if (used_count_t'(j) < avail + ins_n) begin
        merged[j]       = ins_entries_i[ins_count_t'(rel)];  // new entries land behind the old
        merged_valid[j] = 1'b1;
      end
    end
  end

  always_comb begin
    logic run;
    run         = flush_i;
    flush_count = '0;
    for (int j = 0; j < `IQ_DEPTH; j++) begin
      run         = run & merged_valid[j] & (merged[j].stream == flush_stream_i);
      flush_count = flush_count + used_count_t'(run);
    end
  end

  always_comb begin
    used_count_t idx;
    for (int k = 0; k < `IQ_LANE_COUNT; k++) begin
      idx               = flush_count + used_count_t'(k);
      win_next[k]       = merged[iq_ptr_t'(idx)];
      win_valid_next[k] = (idx < used_count_t'(`IQ_DEPTH)) && merged_valid[iq_ptr_t'(idx)];
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      head         <= '0;
      tail         <= '0;
      used_count_o <= '0;
      win_valid    <= '0;
    end else begin
      head         <= head + iq_ptr_t'(issue_count + flush_count);
      tail         <= tail + iq_ptr_t'(ins_n);
      used_count_o <= used_next;
      win_valid    <= win_valid_next;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < `IQ_INS_COUNT; i++) begin
      if (ins_accept && ins_count_t'(i) <= ins_count_i) begin
        storage[tail + iq_ptr_t'(i)] <= ins_entries_i[i];
      end
    end
    win_entry <= win_next;
  end

  a_full_no_growth: assert property (@(posedge clock) disable iff (!reset_n)
    full_o |=> used_count_o <= $past(used_count_o));  // blocked inserts leave only the drains

  a_used_bound: assert property (@(posedge clock) disable iff (!reset_n)
    used_count_o <= used_count_t'(`IQ_DEPTH));

endmodule

// ==== source/iq_pkg.sv ====
`include "iq_settings.svh"

package iq_pkg;

  typedef logic [`IQ_DATA_BITS-1:0] data_t;
  typedef logic [`IQ_ROB_BITS-1:0]  rob_slot_t;

  typedef logic [1:0] opcode_t;

  localparam opcode_t OP_ADD = 2'd0;
  localparam opcode_t OP_SUB = 2'd1;  // src_a minus src_b
  localparam opcode_t OP_XOR = 2'd2;
  localparam opcode_t OP_MUL = 2'd3;  // low half of the product

  typedef logic [$clog2(`IQ_INS_COUNT)-1:0]  ins_count_t;  // number of inserts minus one
  typedef logic [$clog2(`IQ_DEPTH+1)-1:0]    used_count_t;
  typedef logic [$clog2(`IQ_DEPTH)-1:0]      iq_ptr_t;
  typedef logic [$clog2(`IQ_LANE_COUNT)-1:0] lane_idx_t;

  typedef struct packed {
    opcode_t   opcode;
    data_t     src_a;
    data_t     src_b;
    rob_slot_t rob_slot;
    logic      stream;
  } iq_entry_t;

  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_MUL,
    LANE_HOLD
  } lane_state_e;

endpackage

// ==== source/iq_settings.svh ====
`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// queue sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define IQ_DEPTH      16  // entries held in the circular buffer
`define IQ_INS_COUNT  4   // most entries written in one cycle
`define IQ_LANE_COUNT 4   // execution lanes, also the issue window

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// field widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define IQ_DATA_BITS  16  // operand and result width
`define IQ_ROB_BITS   5   // reorder buffer slot tag

`endif

// ==== source/iq_subsystem.sv ====
`timescale 1ns/1ns
`include "iq_settings.svh"

module iq_subsystem (
  input  logic                clock,
  input  logic                reset_n,
  input  logic                ins_enable_i,
  input  iq_pkg::ins_count_t  ins_count_i,
  input  iq_pkg::opcode_t     ins_opcode_i [`IQ_INS_COUNT],
  input  iq_pkg::data_t       ins_src_a_i [`IQ_INS_COUNT],
  input  iq_pkg::data_t       ins_src_b_i [`IQ_INS_COUNT],
  input  iq_pkg::rob_slot_t   ins_rob_slot_i [`IQ_INS_COUNT],
  input  logic                ins_stream_i [`IQ_INS_COUNT],
  input  logic                flush_i,
  input  logic                flush_stream_i,
  input  logic                wb_stall_i,
  output logic                full_o,
  output logic                empty_o,
  output iq_pkg::used_count_t used_count_o,
  output logic                wb_valid_o,
  output iq_pkg::rob_slot_t   wb_rob_slot_o,
  output iq_pkg::data_t       wb_value_o
);
  import iq_pkg::*;

  iq_entry_t ins_entries [`IQ_INS_COUNT];

  issue_if  issue_bus [`IQ_LANE_COUNT] ();
  result_if result_bus [`IQ_LANE_COUNT] ();

  for (genvar i = 0; i < `IQ_INS_COUNT; i++) begin : g_pack
    assign ins_entries[i] = '{
      opcode:   ins_opcode_i[i],
      src_a:    ins_src_a_i[i],
      src_b:    ins_src_b_i[i],
      rob_slot: ins_rob_slot_i[i],
      stream:   ins_stream_i[i]
    };
  end

  instr_queue i_instr_queue (
    .clock          (clock),
    .reset_n        (reset_n),
    .ins_enable_i   (ins_enable_i),
    .ins_count_i    (ins_count_i),
    .ins_entries_i  (ins_entries),
    .flush_i        (flush_i),
    .flush_stream_i (flush_stream_i),
    .issue          (issue_bus),
    .full_o         (full_o),
    .empty_o        (empty_o),
    .used_count_o   (used_count_o)
  );

  for (genvar g = 0; g < `IQ_LANE_COUNT; g++) begin : g_lane
    exec_lane i_exec_lane (
      .clock   (clock),
      .reset_n (reset_n),
      .issue   (issue_bus[g]),
      .result  (result_bus[g])
    );
  end

  writeback_arbiter i_writeback_arbiter (
    .clock         (clock),
    .reset_n       (reset_n),
    .results       (result_bus),
    .wb_stall_i    (wb_stall_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rob_slot_o (wb_rob_slot_o),
    .wb_value_o    (wb_value_o)
  );

endmodule

// ==== source/issue_if.sv ====
`timescale 1ns/1ns

interface issue_if;
  import iq_pkg::*;

  logic      issue;     // lane latches the fields on this edge
  opcode_t   opcode;
  data_t     src_a;
  data_t     src_b;
  rob_slot_t rob_slot;
  logic      ready;

  modport queue (
    output issue,
    output opcode,
    output src_a,
    output src_b,
    output rob_slot,
    input  ready
  );

  modport lane (
    input  issue,
    input  opcode,
    input  src_a,
    input  src_b,
    input  rob_slot,
    output ready
  );

endinterface

// ==== source/result_if.sv ====
`timescale 1ns/1ns

interface result_if;
  import iq_pkg::*;

  logic      valid;     // held with stable fields until taken
  rob_slot_t rob_slot;
  data_t     value;
  logic      take;      // one cycle strobe from the arbiter

  modport lane (
    output valid,
    output rob_slot,
    output value,
    input  take
  );

  modport arbiter (
    input  valid,
    input  rob_slot,
    input  value,
    output take
  );

endinterface

// ==== source/writeback_arbiter.sv ====
`timescale 1ns/1ns
`include "iq_settings.svh"

module writeback_arbiter (
  input  logic              clock,
  input  logic              reset_n,
  result_if.arbiter         results [`IQ_LANE_COUNT],
  input  logic              wb_stall_i,
  output logic              wb_valid_o,
  output iq_pkg::rob_slot_t wb_rob_slot_o,
  output iq_pkg::data_t     wb_value_o
);
  import iq_pkg::*;

  logic [`IQ_LANE_COUNT-1:0] valid_vec;
  logic [`IQ_LANE_COUNT-1:0] take_vec;
  rob_slot_t                 slot_vec [`IQ_LANE_COUNT];
  data_t                     value_vec [`IQ_LANE_COUNT];
  lane_idx_t                 last_grant;
  lane_idx_t                 grant_idx;
  logic                      grant_found;
  logic                      take_any;

  for (genvar g = 0; g < `IQ_LANE_COUNT; g++) begin : g_lane
    assign valid_vec[g]    = results[g].valid;
    assign slot_vec[g]     = results[g].rob_slot;
    assign value_vec[g]    = results[g].value;
    assign results[g].take = take_vec[g];
  end

  // first valid lane after the last one granted
  always_comb begin
    lane_idx_t cand;
    grant_found = 1'b0;
    grant_idx   = last_grant;
    for (int i = 1; i <= `IQ_LANE_COUNT; i++) begin
      cand = lane_idx_t'((int'(last_grant) + i) % `IQ_LANE_COUNT);
      if (!grant_found && valid_vec[cand]) begin
        grant_found = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  assign take_any = grant_found & ~wb_stall_i;  // stall leaves results waiting in the lanes

  always_comb begin
    take_vec            = '0;
    take_vec[grant_idx] = take_any;
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      wb_valid_o <= 1'b0;
      last_grant <= lane_idx_t'(`IQ_LANE_COUNT - 1);  // lane 0 goes first
    end else begin
      wb_valid_o <= take_any;
      if (take_any) last_grant <= grant_idx;
    end
  end

  always_ff @(posedge clock) begin
    if (take_any) begin
      wb_rob_slot_o <= slot_vec[grant_idx];
      wb_value_o    <= value_vec[grant_idx];
    end
  end

  // a lane left waiting wins over the lane that was just granted
  a_rotate_grant: assert property (@(posedge clock) disable iff (!reset_n)
    take_any && ((valid_vec & ~take_vec) != '0) |=> !take_vec[last_grant]);

endmodule

// ==== testbench/tb_iq_subsystem.sv ====
`timescale 1ns/1ns
`include "iq_settings.svh"

module tb_iq_subsystem;
  import iq_pkg::*;

  localparam int SLOTS         = 2 ** `IQ_ROB_BITS;
  localparam int FULL_LEVEL    = `IQ_DEPTH - `IQ_INS_COUNT;
  localparam int DRAIN_LIMIT   = 200;
  localparam int RANDOM_CYCLES = 150;
  localparam int FILL_CYCLES   = 12;
  localparam int FLUSH_CYCLES  = 8;
  localparam int MIXED_CYCLES  = 60;
  localparam int RUN_CYCLES    = 4 + 5 + RANDOM_CYCLES + FILL_CYCLES + FLUSH_CYCLES
                                 + MIXED_CYCLES + 2 * DRAIN_LIMIT;
  localparam int MARGIN_CYCLES = 100;

  logic        clock = 1'b0;
  logic        reset_n;
  logic        ins_enable;
  ins_count_t  ins_count;
  opcode_t     ins_opcode [`IQ_INS_COUNT];
  data_t       ins_src_a [`IQ_INS_COUNT];
  data_t       ins_src_b [`IQ_INS_COUNT];
  rob_slot_t   ins_rob_slot [`IQ_INS_COUNT];
  logic        ins_stream [`IQ_INS_COUNT];
  logic        flush;
  logic        flush_stream;
  logic        wb_stall;
  logic        full_o;
  logic        empty_o;
  used_count_t used_count_o;
  logic        wb_valid_o;
  rob_slot_t   wb_rob_slot_o;
  data_t       wb_value_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  data_t             exp_val [SLOTS];
  logic              stream_of [SLOTS];
  logic [SLOTS-1:0]  outstanding = '0;
  int                n_outstanding = 0;
  rob_slot_t         next_slot = '0;
  rob_slot_t         model_q [$];      // slots still stored in the queue
  int                model_used = 0;
  logic              lanes_free = 1'b1; // all four lanes idle
  logic              count_check_en = 1'b0;
  logic [3:0]        op_seen = '0;
  int                test_id = 0;
  int                tests_run = 0;
  int                error_count = 0;
  int                errors_before = 0;

  iq_subsystem i_iq_subsystem (
    .clock          (clock),
    .reset_n        (reset_n),
    .ins_enable_i   (ins_enable),
    .ins_count_i    (ins_count),
    .ins_opcode_i   (ins_opcode),
    .ins_src_a_i    (ins_src_a),
    .ins_src_b_i    (ins_src_b),
    .ins_rob_slot_i (ins_rob_slot),
    .ins_stream_i   (ins_stream),
    .flush_i        (flush),
    .flush_stream_i (flush_stream),
    .wb_stall_i     (wb_stall),
    .full_o         (full_o),
    .empty_o        (empty_o),
    .used_count_o   (used_count_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rob_slot_o  (wb_rob_slot_o),
    .wb_value_o     (wb_value_o)
  );

  always #5 clock = ~clock;

  function automatic data_t expected_result(input opcode_t op, input data_t a, input data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      default: return a * b;  // only the low half is kept
    endcase
  endfunction

  // extract then insert then flush within one edge
  always @(posedge clock) begin
    int        issued;
    rob_slot_t slot;
    if (wb_valid_o && outstanding[wb_rob_slot_o]) begin
      outstanding[wb_rob_slot_o] = 1'b0;  // retired before a new insert may reuse the slot
      n_outstanding = n_outstanding - 1;
    end
    issued = 0;
    if (count_check_en && lanes_free) begin
      issued = (model_q.size() < `IQ_LANE_COUNT) ? model_q.size() : `IQ_LANE_COUNT;
    end
    repeat (issued) void'(model_q.pop_front());
    if (issued > 0) lanes_free = 1'b0;  // stalled lanes keep holding
    if (ins_enable && !(count_check_en && model_used > FULL_LEVEL)) begin
      for (int i = 0; i <= int'(ins_count); i++) begin
        slot                   = ins_rob_slot[i];
        exp_val[slot]          = expected_result(ins_opcode[i], ins_src_a[i], ins_src_b[i]);
        stream_of[slot]        = ins_stream[i];
        op_seen[ins_opcode[i]] = 1'b1;
        outstanding[slot]      = 1'b1;
        n_outstanding          = n_outstanding + 1;
        if (count_check_en) model_q.push_back(slot);
      end
      next_slot = next_slot + rob_slot_t'(int'(ins_count) + 1);
    end
    if (count_check_en && flush) begin
      while (model_q.size() > 0 && stream_of[model_q[0]] == flush_stream) begin
        slot              = model_q.pop_front();
        outstanding[slot] = 1'b0;  // a flushed slot must never come back
        n_outstanding     = n_outstanding - 1;
      end
    end
    if (count_check_en) model_used = model_q.size();
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_reset_state: assert property (@(negedge clock) disable iff (!reset_n)
    (test_id == 1) |-> (empty_o && !full_o && !wb_valid_o && used_count_o == '0))
    else begin
      $display("[ERROR] %0t ns: after reset empty %b full %b wb_valid %b used %0d",
               $time, empty_o, full_o, wb_valid_o, used_count_o);
      error_count = error_count + 1;
    end

  a_wb_slot_live: assert property (@(negedge clock) disable iff (!reset_n)
    wb_valid_o |-> outstanding[wb_rob_slot_o])
    else begin
      $display("[ERROR] %0t ns: writeback of slot %0d which is not outstanding",
               $time, wb_rob_slot_o);
      error_count = error_count + 1;
    end

  a_wb_value: assert property (@(negedge clock) disable iff (!reset_n)
    wb_valid_o |-> (wb_value_o == exp_val[wb_rob_slot_o]))
    else begin
      $display("[ERROR] %0t ns: slot %0d value %h expected %h",
               $time, wb_rob_slot_o, wb_value_o, exp_val[wb_rob_slot_o]);
      error_count = error_count + 1;
    end

  a_used_count: assert property (@(negedge clock) disable iff (!reset_n)
    count_check_en |-> (used_count_o == used_count_t'(model_used)))
    else begin
      $display("[ERROR] %0t ns: used count %0d expected %0d", $time, used_count_o, model_used);
      error_count = error_count + 1;
    end

  a_full_empty_flags: assert property (@(negedge clock) disable iff (!reset_n)
    count_check_en |-> (full_o == (model_used > FULL_LEVEL))
                       && (empty_o == (model_used == 0)))
    else begin
      $display("[ERROR] %0t ns: full %b empty %b with model count %0d",
               $time, full_o, empty_o, model_used);
      error_count = error_count + 1;
    end

  a_no_wb_after_stall: assert property (@(negedge clock) disable iff (!reset_n)
    wb_stall |=> !wb_valid_o)
    else begin
      $display("[ERROR] %0t ns: writeback right after a stalled cycle", $time);
      error_count = error_count + 1;
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic drive_idle();
    ins_enable = 1'b0;
    flush      = 1'b0;
  endtask

  task automatic insert_random(input int n);
    for (int i = 0; i < `IQ_INS_COUNT; i++) begin
      ins_opcode[i]   = opcode_t'($urandom);
      ins_src_a[i]    = data_t'($urandom);
      ins_src_b[i]    = data_t'($urandom);
      ins_stream[i]   = 1'($urandom);
      ins_rob_slot[i] = next_slot + rob_slot_t'(i);  // slots rise modulo 32
    end
    ins_count  = ins_count_t'(n - 1);
    ins_enable = 1'b1;
    flush      = 1'b0;
  endtask

  task automatic drain_all();
    int waited;
    waited   = 0;
    wb_stall = 1'b0;
    drive_idle();
    while (n_outstanding != 0 && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (n_outstanding != 0) begin
      $display("drain timed out with %0d results never written back", n_outstanding);
      error_count = error_count + 1;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s finished with %0d errors", test_id, name, error_count - errors_before);
    errors_before = error_count;
  endtask

  initial begin
    #((RUN_CYCLES + MARGIN_CYCLES) * 10);
    $display("watchdog expired before the tests completed");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    void'($urandom(58132));
    reset_n      = 1'b0;
    wb_stall     = 1'b0;
    flush_stream = 1'b0;
    ins_count    = '0;
    insert_random(1);
    drive_idle();
    repeat (4) @(posedge clock);
    #1;
    reset_n = 1'b1;

    test_id = 1;
    repeat (5) next_cycle();
    finish_test("reset state");

    test_id = 2;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      if (!full_o && n_outstanding < 24 && $urandom % 4 != 0) insert_random(1 + int'($urandom % 4));
      else drive_idle();
      next_cycle();
    end
    drain_all();
    if (op_seen != 4'hf) begin
      $display("random traffic did not use every opcode, seen %b", op_seen);
      error_count = error_count + 1;
    end
    finish_test("random traffic");

    test_id = 3;
    model_q.delete();
    model_used     = 0;
    lanes_free     = 1'b1;
    count_check_en = 1'b1;
    wb_stall       = 1'b1;
    for (int c = 0; c < FILL_CYCLES; c++) begin
      insert_random(1 + int'($urandom % 4));  // inserts go on while full and the model drops them
      next_cycle();
    end
    drive_idle();
    finish_test("fill under stall");

    test_id = 4;
    for (int f = 0; f < 2; f++) begin
      if (f == 1) insert_random(2);
      if (model_q.size() > 0) begin
        flush_stream = stream_of[model_q[0]];  // the head's stream gives a nonempty run
        flush        = 1'b1;
      end
      next_cycle();
      drive_idle();
      repeat (3) next_cycle();
    end
    finish_test("stream flush");

    test_id        = 5;
    count_check_en = 1'b0;
    for (int c = 0; c < MIXED_CYCLES; c++) begin
      wb_stall = ($urandom % 3 == 0);
      if (!full_o && n_outstanding < 24 && $urandom % 2 == 0) insert_random(1 + int'($urandom % 4));
      else drive_idle();
      next_cycle();
    end
    drain_all();
    finish_test("stall release");

    $display("tests run: %0d, errors: %0d", tests_run, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
